/* hw/l1d_pkg.sv */
// L1 data cache package with shared geometry constants and enum types
`default_nettype none

package l1d_pkg;

  // ==================================================
  // Geometry
  // ==================================================
  localparam int addr_bits   = 32;
  localparam int word_bits   = 32;
  localparam int line_words  = 4;
  localparam int line_bytes  = 16;
  localparam int offset_bits = 4;
  localparam int line_bits   = line_words * word_bits;

  // ==================================================
  // Types
  // ==================================================
  // Access size encoding shared by core and memory side
  typedef enum logic [1:0] {
    SIZE_BYTE = 2'd0,
    SIZE_HALF = 2'd1,
    SIZE_WORD = 2'd2
  } mem_size_e;

  // Controller states
  typedef enum logic [2:0] {
    ST_IDLE       = 3'd0,
    ST_LOOKUP     = 3'd1,
    ST_REFILL     = 3'd2,
    ST_FILL_DONE  = 3'd3,
    ST_WRITE_THRU = 3'd4
  } ctrl_state_e;

endpackage

`default_nettype wire

/* hw/l1d_tag_store.sv */
// Tag array with per-line valid bits and a registered lookup port
`timescale 1ns/1ps
`default_nettype none

module l1d_tag_store #(
  parameter int INDEX_BITS = 6
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [INDEX_BITS-1:0] index,
  input  logic                  tag_we,
  input  logic [l1d_pkg::addr_bits-INDEX_BITS-l1d_pkg::offset_bits-1:0] tag_wdata,
  output logic [l1d_pkg::addr_bits-INDEX_BITS-l1d_pkg::offset_bits-1:0] tag_rdata,
  output logic                  line_valid
);

  localparam int tag_bits = l1d_pkg::addr_bits - INDEX_BITS - l1d_pkg::offset_bits;
  localparam int lines    = 2 ** INDEX_BITS;

  logic [tag_bits-1:0] tag_mem [lines];
  logic [lines-1:0]    valid_q;

  // Tag write and registered tag read
  always_ff @(posedge clk)
  begin
    if (tag_we)
    begin
      tag_mem[index] <= tag_wdata;
    end
    tag_rdata <= tag_mem[index];
  end

  // Valid bits are all cleared by reset
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      valid_q    <= '0;
      line_valid <= 1'b0;
    end
    else
    begin
      if (tag_we)
      begin
        valid_q[index] <= 1'b1;
      end
      line_valid <= valid_q[index];
    end
  end

endmodule

`default_nettype wire

/* hw/l1d_data_store.sv */
// Line data array with per-byte write enables and a registered read
`timescale 1ns/1ps
`default_nettype none

module l1d_data_store #(
  parameter int INDEX_BITS = 6
) (
  input  logic                            clk,
  input  logic [INDEX_BITS-1:0]           index,
  input  logic [l1d_pkg::line_bytes-1:0]  byte_we,
  input  logic [l1d_pkg::line_bits-1:0]   line_wdata,
  output logic [l1d_pkg::line_bits-1:0]   line_rdata
);

  localparam int lines = 2 ** INDEX_BITS;

  // One byte per entry so each lane writes on its own
  logic [7:0] data_mem [lines][l1d_pkg::line_bytes];

  always_ff @(posedge clk)
  begin
    for (int b = 0; b < l1d_pkg::line_bytes; b++)
    begin
      if (byte_we[b])
      begin
        data_mem[index][b] <= line_wdata[b*8 +: 8];
      end
    end
  end

  // Old contents come out when read and write hit the same line
  always_ff @(posedge clk)
  begin
    for (int b = 0; b < l1d_pkg::line_bytes; b++)
    begin
      line_rdata[b*8 +: 8] <= data_mem[index][b];
    end
  end

endmodule

`default_nettype wire

/* hw/l1d_store_merge.sv */
// Store data placement into a cache line and byte enable generation
`timescale 1ns/1ps
`default_nettype none

module l1d_store_merge (
  input  logic [l1d_pkg::offset_bits-1:0] req_offset,
  input  l1d_pkg::mem_size_e              req_size,
  input  logic [l1d_pkg::word_bits-1:0]   req_wdata,
  output logic [l1d_pkg::line_bits-1:0]   merge_data,
  output logic [l1d_pkg::line_bytes-1:0]  merge_be
);

  logic [1:0]                      slot;
  logic [1:0]                      lane;
  logic [3:0]                      word_be;
  logic [l1d_pkg::word_bits-1:0]   word_data;

  assign slot = req_offset[3:2];
  assign lane = req_offset[1:0];

  // Little-endian lanes within the word
  always_comb
  begin
    case (req_size)
      l1d_pkg::SIZE_BYTE:
      begin
        word_be   = 4'b0001 << lane;
        word_data = {4{req_wdata[7:0]}};
      end
      l1d_pkg::SIZE_HALF:
      begin
        word_be   = lane[1] ? 4'b1100 : 4'b0011;
        word_data = {2{req_wdata[15:0]}};
      end
      default:
      begin
        word_be   = 4'b1111;
        word_data = req_wdata;
      end
    endcase
  end

  // Same word placed in every slot and the enables pick the slot
  always_comb
  begin
    merge_data = {l1d_pkg::line_words{word_data}};
    for (int w = 0; w < l1d_pkg::line_words; w++)
    begin
      merge_be[w*4 +: 4] = (slot == 2'(w)) ? word_be : 4'b0000;
    end
  end

endmodule

`default_nettype wire

/* hw/l1d_ctrl.sv */
// Cache controller with hit check, line refill and write-through sequencing
`timescale 1ns/1ps
`default_nettype none

module l1d_ctrl #(
  parameter int INDEX_BITS = 6
) (
  input  logic                            clk,
  input  logic                            rst,
  // Core side
  input  logic                            core_req,
  input  logic                            core_write,
  input  logic [l1d_pkg::addr_bits-1:0]   core_addr,
  input  logic [l1d_pkg::word_bits-1:0]   core_wdata,
  input  l1d_pkg::mem_size_e              core_size,
  output logic                            core_wait,
  output logic [l1d_pkg::word_bits-1:0]   core_rdata,
  // Memory side
  input  logic                            mem_wait,
  input  logic [l1d_pkg::word_bits-1:0]   mem_rdata,
  output logic                            mem_req,
  output logic                            mem_write,
  output logic [l1d_pkg::addr_bits-1:0]   mem_addr,
  output logic [l1d_pkg::word_bits-1:0]   mem_wdata,
  output l1d_pkg::mem_size_e              mem_size,
  // Tag store
  output logic [INDEX_BITS-1:0]           tag_index,
  output logic                            tag_we,
  output logic [l1d_pkg::addr_bits-INDEX_BITS-l1d_pkg::offset_bits-1:0] tag_wdata,
  input  logic [l1d_pkg::addr_bits-INDEX_BITS-l1d_pkg::offset_bits-1:0] tag_rdata,
  input  logic                            line_valid,
  // Data store
  output logic [INDEX_BITS-1:0]           data_index,
  output logic [l1d_pkg::line_bytes-1:0]  byte_we,
  output logic [l1d_pkg::line_bits-1:0]   line_wdata,
  input  logic [l1d_pkg::line_bits-1:0]   line_rdata,
  // Store merge
  output logic [l1d_pkg::offset_bits-1:0] req_offset,
  output l1d_pkg::mem_size_e              req_size,
  output logic [l1d_pkg::word_bits-1:0]   req_wdata,
  input  logic [l1d_pkg::line_bits-1:0]   merge_data,
  input  logic [l1d_pkg::line_bytes-1:0]  merge_be
);

  localparam int tag_bits = l1d_pkg::addr_bits - INDEX_BITS - l1d_pkg::offset_bits;

  l1d_pkg::ctrl_state_e        state;
  l1d_pkg::ctrl_state_e        state_nxt;
  logic [l1d_pkg::addr_bits-1:0] req_addr;
  logic                        req_write;
  logic [1:0]                  beat;
  logic [1:0]                  req_slot;
  logic [INDEX_BITS-1:0]       req_index;
  logic [tag_bits-1:0]         req_tag;
  logic                        accept;
  logic                        hit;
  logic                        beat_done;

  assign accept    = (state == l1d_pkg::ST_IDLE) && core_req;
  assign req_slot  = req_addr[3:2];
  assign req_index = req_addr[l1d_pkg::offset_bits +: INDEX_BITS];
  assign req_tag   = req_addr[l1d_pkg::addr_bits-1 -: tag_bits];
  assign hit       = line_valid && (tag_rdata == req_tag);
  assign beat_done = (state == l1d_pkg::ST_REFILL) && !mem_wait;

  // ==================================================
  // Request latch and state
  // ==================================================
  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      req_addr   <= core_addr;
      req_write  <= core_write;
      req_wdata  <= core_wdata;
      req_size   <= core_size;
    end
  end

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      state <= l1d_pkg::ST_IDLE;
      beat  <= 2'd0;
    end
    else
    begin
      state <= state_nxt;
      // Wraps back to zero after the last word
      if (beat_done)
      begin
        beat <= beat + 2'd1;
      end
    end
  end

  always_comb
  begin
    state_nxt = state;
    case (state)
      l1d_pkg::ST_IDLE:
        if (core_req) state_nxt = l1d_pkg::ST_LOOKUP;
      l1d_pkg::ST_LOOKUP:
        if (req_write)  state_nxt = l1d_pkg::ST_WRITE_THRU;
        else if (hit)   state_nxt = l1d_pkg::ST_IDLE;
        else            state_nxt = l1d_pkg::ST_REFILL;
      l1d_pkg::ST_REFILL:
        if (beat_done && beat == 2'd3) state_nxt = l1d_pkg::ST_FILL_DONE;
      l1d_pkg::ST_FILL_DONE:
        state_nxt = l1d_pkg::ST_IDLE;
      l1d_pkg::ST_WRITE_THRU:
        if (!mem_wait) state_nxt = l1d_pkg::ST_IDLE;
      default:
        state_nxt = l1d_pkg::ST_IDLE;
    endcase
  end

  // Load data comes from the hit line or from the refill beat of the requested slot
  always_ff @(posedge clk)
  begin
    if (state == l1d_pkg::ST_LOOKUP && !req_write && hit)
    begin
      core_rdata <= line_rdata[req_slot*l1d_pkg::word_bits +: l1d_pkg::word_bits];
    end
    else if (beat_done && beat == req_slot)
    begin
      core_rdata <= mem_rdata;
    end
  end

  // ==================================================
  // Outputs
  // ==================================================
  assign core_wait  = (state != l1d_pkg::ST_IDLE) || core_req;
  assign req_offset = req_addr[l1d_pkg::offset_bits-1:0];

  // Index goes out straight from the core in the acceptance cycle
  assign tag_index  = accept ? core_addr[l1d_pkg::offset_bits +: INDEX_BITS] : req_index;
  assign data_index = tag_index;
  assign tag_we     = (state == l1d_pkg::ST_FILL_DONE);
  assign tag_wdata  = req_tag;

  always_comb
  begin
    byte_we    = '0;
    line_wdata = {l1d_pkg::line_words{mem_rdata}};
    if (state == l1d_pkg::ST_LOOKUP && req_write && hit)
    begin
      byte_we    = merge_be;
      line_wdata = merge_data;
    end
    else if (beat_done)
    begin
      byte_we[beat*4 +: 4] = 4'b1111;
    end
  end

  assign mem_req   = (state == l1d_pkg::ST_REFILL) || (state == l1d_pkg::ST_WRITE_THRU);
  assign mem_write = (state == l1d_pkg::ST_WRITE_THRU);
  assign mem_wdata = req_wdata;
  assign mem_size  = mem_write ? req_size : l1d_pkg::SIZE_WORD;
  assign mem_addr  = mem_write ? req_addr :
                     {req_addr[l1d_pkg::addr_bits-1:l1d_pkg::offset_bits], beat, 2'b00};

endmodule

`default_nettype wire

/* hw/l1d_cache.sv */
// Direct-mapped write-through L1 data cache top level
`timescale 1ns/1ps
`default_nettype none

module l1d_cache #(
  parameter int INDEX_BITS = 6
) (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          core_req,
  input  logic                          core_write,
  input  logic [l1d_pkg::addr_bits-1:0] core_addr,
  input  logic [l1d_pkg::word_bits-1:0] core_wdata,
  input  l1d_pkg::mem_size_e            core_size,
  output logic                          core_wait,
  output logic [l1d_pkg::word_bits-1:0] core_rdata,
  input  logic                          mem_wait,
  input  logic [l1d_pkg::word_bits-1:0] mem_rdata,
  output logic                          mem_req,
  output logic                          mem_write,
  output logic [l1d_pkg::addr_bits-1:0] mem_addr,
  output logic [l1d_pkg::word_bits-1:0] mem_wdata,
  output l1d_pkg::mem_size_e            mem_size
);

  localparam int tag_bits = l1d_pkg::addr_bits - INDEX_BITS - l1d_pkg::offset_bits;

  logic [INDEX_BITS-1:0]           tag_index;
  logic                            tag_we;
  logic [tag_bits-1:0]             tag_wdata;
  logic [tag_bits-1:0]             tag_rdata;
  logic                            line_valid;
  logic [INDEX_BITS-1:0]           data_index;
  logic [l1d_pkg::line_bytes-1:0]  byte_we;
  logic [l1d_pkg::line_bits-1:0]   line_wdata;
  logic [l1d_pkg::line_bits-1:0]   line_rdata;
  logic [l1d_pkg::offset_bits-1:0] req_offset;
  l1d_pkg::mem_size_e              req_size;
  logic [l1d_pkg::word_bits-1:0]   req_wdata;
  logic [l1d_pkg::line_bits-1:0]   merge_data;
  logic [l1d_pkg::line_bytes-1:0]  merge_be;

  l1d_ctrl #(.INDEX_BITS(INDEX_BITS)) i_ctrl (
    .clk, .rst,
    .core_req, .core_write, .core_addr, .core_wdata, .core_size, .core_wait, .core_rdata,
    .mem_wait, .mem_rdata, .mem_req, .mem_write, .mem_addr, .mem_wdata, .mem_size,
    .tag_index, .tag_we, .tag_wdata, .tag_rdata, .line_valid,
    .data_index, .byte_we, .line_wdata, .line_rdata,
    .req_offset, .req_size, .req_wdata, .merge_data, .merge_be
  );

  l1d_tag_store #(.INDEX_BITS(INDEX_BITS)) i_tag_store (
    .clk, .rst, .index(tag_index), .tag_we, .tag_wdata, .tag_rdata, .line_valid
  );

  l1d_data_store #(.INDEX_BITS(INDEX_BITS)) i_data_store (
    .clk, .index(data_index), .byte_we, .line_wdata, .line_rdata
  );

  l1d_store_merge i_store_merge (
    .req_offset, .req_size, .req_wdata, .merge_data, .merge_be
  );

endmodule

`default_nettype wire

/* verif/l1d_mem_model.sv */
// Word-wide behavioral memory with random wait states and transfer counters
`timescale 1ns/1ps
`default_nettype none

module l1d_mem_model #(
  parameter int          WORDS = 1024,
  parameter logic [31:0] SEED  = 32'h0000_0001
) (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          mem_req,
  input  logic                          mem_write,
  input  logic [l1d_pkg::addr_bits-1:0] mem_addr,
  input  logic [l1d_pkg::word_bits-1:0] mem_wdata,
  input  l1d_pkg::mem_size_e            mem_size,
  output logic                          mem_wait,
  output logic [l1d_pkg::word_bits-1:0] mem_rdata,
  output int                            read_count,
  output int                            write_count
);

  logic [31:0]               mem [WORDS];
  logic [31:0]               lfsr;
  logic [1:0]                delay;
  logic [$clog2(WORDS)-1:0]  word_idx;

  // Galois LFSR stepped once per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++)
    begin
      r    = {r[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
    end
    return r;
  endfunction

  // Fill mixes the byte address into every word
  initial
  begin
    lfsr = SEED;
    for (int a = 0; a < WORDS; a++)
    begin
      mem[a] <= rand_bits(32) ^ 32'(a * 4);
    end
  end

  assign word_idx  = mem_addr[2 +: $clog2(WORDS)];
  assign mem_rdata = mem[word_idx];
  assign mem_wait  = mem_req && (delay != 2'd0);

  // ==================================================
  // Transfer completion
  // ==================================================
  always @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      delay       <= 2'd0;
      read_count  <= 0;
      write_count <= 0;
    end
    else if (mem_req)
    begin
      if (delay != 2'd0)
      begin
        delay <= delay - 2'd1;
      end
      else
      begin
        // Wait of 0 to 3 cycles for the next transfer
        delay <= 2'(rand_bits(2));
        if (mem_write)
        begin
          case (mem_size)
            l1d_pkg::SIZE_BYTE: mem[word_idx][{mem_addr[1:0], 3'b000} +: 8] <= mem_wdata[7:0];
            l1d_pkg::SIZE_HALF: mem[word_idx][{mem_addr[1], 4'b0000} +: 16] <= mem_wdata[15:0];
            default:            mem[word_idx] <= mem_wdata;
          endcase
          write_count <= write_count + 1;
        end
        else
        begin
          read_count <= read_count + 1;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* verif/tb_l1d_cache.sv */
// Directed testbench for the L1 data cache against a behavioral memory
`timescale 1ns/1ps
`default_nettype none

module tb_l1d_cache;

  localparam logic [31:0] seed         = 32'h89a9_ca9f;
  localparam int          clk_period   = 20;
  localparam int          mem_words    = 1024;
  localparam int          num_tests    = 6;
  // Refill with the longest wait on all four beats plus lookup
  localparam int          worst_cycles = 4 * 4 + 4;
  localparam int          max_accesses = 12;
  localparam int          margin       = 4;
  localparam int          watchdog_ns  =
    num_tests * max_accesses * worst_cycles * margin * clk_period;

  logic               clk;
  logic               rst;
  logic               core_req;
  logic               core_write;
  logic [31:0]        core_addr;
  logic [31:0]        core_wdata;
  l1d_pkg::mem_size_e core_size;
  logic               core_wait;
  logic [31:0]        core_rdata;
  logic               mem_wait;
  logic [31:0]        mem_rdata;
  logic               mem_req;
  logic               mem_write;
  logic [31:0]        mem_addr;
  logic [31:0]        mem_wdata;
  l1d_pkg::mem_size_e mem_size;
  int                 read_count;
  int                 write_count;
  int                 error_count = 0;
  int                 check_count = 0;
  int                 test_count = 0;
  int                 test_base = 0;

  l1d_cache #(.INDEX_BITS(6)) i_l1d_cache (
    .clk, .rst,
    .core_req, .core_write, .core_addr, .core_wdata, .core_size, .core_wait, .core_rdata,
    .mem_wait, .mem_rdata, .mem_req, .mem_write, .mem_addr, .mem_wdata, .mem_size
  );

  l1d_mem_model #(.WORDS(mem_words), .SEED(seed)) i_mem_model (
    .clk, .rst,
    .mem_req, .mem_write, .mem_addr, .mem_wdata, .mem_size, .mem_wait, .mem_rdata,
    .read_count, .write_count
  );

  initial
  begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  initial
  begin
    #(watchdog_ns);
    $display("Watchdog expired before the tests finished");
    $display("Test failed");
    $finish;
  end

  // ==================================================
  // Helpers
  // ==================================================
  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    check_count++;
    if (got !== exp)
    begin
      $display("** Error: %s = %h, expected %h", name, got, exp);
      error_count++;
    end
  endtask

  task automatic end_test(input string name);
    if (error_count == test_base)
      $display("%s: ok", name);
    else
      $display("%s: %0d errors", name, error_count - test_base);
    test_base = error_count;
    test_count++;
  endtask

  function automatic logic [31:0] model_word(input logic [31:0] addr);
    return i_mem_model.mem[addr[2 +: $clog2(mem_words)]];
  endfunction

  // Little-endian lane rule for sub-word stores
  function automatic logic [31:0] merge_word(input logic [31:0] old, input logic [31:0] data,
                                             input l1d_pkg::mem_size_e size,
                                             input logic [1:0] lane);
    logic [31:0] mask;
    logic [31:0] placed;
    case (size)
      l1d_pkg::SIZE_BYTE:
      begin
        mask   = 32'h0000_00ff << (8 * lane);
        placed = 32'(data[7:0]) << (8 * lane);
      end
      l1d_pkg::SIZE_HALF:
      begin
        mask   = 32'h0000_ffff << (16 * lane[1]);
        placed = 32'(data[15:0]) << (16 * lane[1]);
      end
      default:
      begin
        mask   = 32'hffff_ffff;
        placed = data;
      end
    endcase
    return (old & ~mask) | (placed & mask);
  endfunction

  // Cycles counted from the edge that presents the request
  task automatic run_access(input logic write, input logic [31:0] addr,
                            input logic [31:0] wdata, input l1d_pkg::mem_size_e size,
                            output logic [31:0] rdata, output int cycles);
    @(posedge clk);
    core_req   <= 1'b1;
    core_write <= write;
    core_addr  <= addr;
    core_wdata <= wdata;
    core_size  <= size;
    @(posedge clk);
    core_req <= 1'b0;
    cycles = 1;
    @(negedge clk);
    while (core_wait)
    begin
      @(negedge clk);
      cycles++;
    end
    rdata = core_rdata;
  endtask

  task automatic read_check(input logic [31:0] addr, input logic [31:0] exp,
                            input int exp_reads, output int cycles);
    logic [31:0] rdata;
    int          reads_before;
    int          writes_before;
    reads_before  = read_count;
    writes_before = write_count;
    run_access(1'b0, addr, '0, l1d_pkg::SIZE_WORD, rdata, cycles);
    check_value("core_rdata", rdata, exp);
    check_value("read transfers", read_count - reads_before, exp_reads);
    check_value("write transfers", write_count - writes_before, 0);
  endtask

  task automatic store_check(input logic [31:0] addr, input logic [31:0] data,
                             input l1d_pkg::mem_size_e size, output logic [31:0] exp);
    logic [31:0] rdata;
    int          cycles;
    int          reads_before;
    int          writes_before;
    exp           = merge_word(model_word(addr), data, size, addr[1:0]);
    reads_before  = read_count;
    writes_before = write_count;
    run_access(1'b1, addr, data, size, rdata, cycles);
    check_value("write transfers", write_count - writes_before, 1);
    check_value("read transfers", read_count - reads_before, 0);
    check_value("memory word", model_word(addr), exp);
  endtask

  // ==================================================
  // Directed tests
  // ==================================================
  task automatic reset_idle();
    @(negedge clk);
    check_value("core_wait", core_wait, 0);
    check_value("mem_req", mem_req, 0);
    end_test("idle after reset");
  endtask

  task automatic miss_then_hit();
    int cycles;
    read_check(32'h0000_0104, model_word(32'h0000_0104), 4, cycles);
    read_check(32'h0000_0104, model_word(32'h0000_0104), 0, cycles);
    check_value("hit latency", cycles, 2);
    end_test("read miss then hit");
  endtask

  task automatic line_fill_reads();
    logic [31:0] addr;
    int          cycles;
    read_check(32'h0000_0208, model_word(32'h0000_0208), 4, cycles);
    for (int w = 0; w < 4; w++)
    begin
      addr = 32'h0000_0200 + 32'(4 * w);
      read_check(addr, model_word(addr), 0, cycles);
    end
    end_test("all words of a refilled line");
  endtask

  task automatic store_hit_merge();
    logic [31:0] exp;
    int          cycles;
    read_check(32'h0000_0300, model_word(32'h0000_0300), 4, cycles);
    store_check(32'h0000_0301, 32'h0000_00a5, l1d_pkg::SIZE_BYTE, exp);
    read_check(32'h0000_0300, exp, 0, cycles);
    store_check(32'h0000_0300, 32'h0000_7e81, l1d_pkg::SIZE_HALF, exp);
    read_check(32'h0000_0300, exp, 0, cycles);
    store_check(32'h0000_0306, 32'h0000_beef, l1d_pkg::SIZE_HALF, exp);
    read_check(32'h0000_0304, exp, 0, cycles);
    store_check(32'h0000_0308, 32'h1234_5678, l1d_pkg::SIZE_WORD, exp);
    read_check(32'h0000_0308, exp, 0, cycles);
    store_check(32'h0000_030f, 32'h0000_003c, l1d_pkg::SIZE_BYTE, exp);
    read_check(32'h0000_030c, exp, 0, cycles);
    end_test("store hits merge into the line");
  endtask

  task automatic store_miss_bypass();
    logic [31:0] exp;
    int          cycles;
    store_check(32'h0000_03a6, 32'h0000_cafe, l1d_pkg::SIZE_HALF, exp);
    read_check(32'h0000_03a4, exp, 4, cycles);
    end_test("store miss goes to memory only");
  endtask

  // Both lines map to index 5
  task automatic same_index_evict();
    int cycles;
    for (int i = 0; i < 3; i++)
    begin
      read_check(32'h0000_0050, model_word(32'h0000_0050), 4, cycles);
      read_check(32'h0000_0458, model_word(32'h0000_0458), 4, cycles);
    end
    end_test("same index evicts");
  endtask

  initial
  begin
    rst        = 1'b1;
    core_req   = 1'b0;
    core_write = 1'b0;
    core_addr  = '0;
    core_wdata = '0;
    core_size  = l1d_pkg::SIZE_WORD;
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    reset_idle();
    miss_then_hit();
    line_fill_reads();
    store_hit_merge();
    store_miss_bypass();
    same_index_evict();
    $display("Tests run: %0d, checks: %0d, errors: %0d", test_count, check_count, error_count);
    if (error_count == 0)
      $display("Test passed");
    else
      $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire

/* build.f */
hw/l1d_pkg.sv
hw/l1d_tag_store.sv
hw/l1d_data_store.sv
hw/l1d_store_merge.sv
hw/l1d_ctrl.sv
hw/l1d_cache.sv
verif/l1d_mem_model.sv
verif/tb_l1d_cache.sv

/* Bender.yml */
package:
  name: l1d_cache

sources:
  - hw/l1d_pkg.sv
  - hw/l1d_tag_store.sv
  - hw/l1d_data_store.sv
  - hw/l1d_store_merge.sv
  - hw/l1d_ctrl.sv
  - hw/l1d_cache.sv
  - target: test
    files:
      - verif/l1d_mem_model.sv
      - verif/tb_l1d_cache.sv
